// ==== sources.f ====
+incdir+.
meta_pred_pkg.sv
branch_slot_select.sv
confidence_bank.sv
confidence_update_ctrl.sv
component_arbiter.sv
meta_predictor_top.sv
tb_meta_predictor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the meta predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module tb_meta_predictor \
  -Mdir obj_dir -o sim_meta_predictor

./obj_dir/sim_meta_predictor | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== meta_pred_model.svh ====
`ifndef meta_pred_model_svh
`define meta_pred_model_svh

// ########################################
// Reference tables
// ########################################

localparam logic [stat_w-1:0] stat_max = '1;
localparam logic [stat_w-1:0] low_mask = stat_w'((1 << clear_bits) - 1);

logic [stat_w-1:0] sp_tab  [meta_pred_pkg::n_branch_types][2];
logic [stat_w-1:0] lhp_tab [meta_pred_pkg::n_branch_types][jump_states];
logic [stat_w-1:0] ghp_tab [meta_pred_pkg::n_branch_types][jump_states];

// Position of the set bit, 0 when none
function automatic int slot_of(input logic [5:0] onehot);
  int k;
  k = 0;
  for (int b = 0; b < meta_pred_pkg::n_branch_types; b++)
    if (onehot[b])
      k = b;
  return k;
endfunction

function automatic logic [jump_w-1:0] local_count(input logic [5:0] onehot,
                                                  input logic [lhp_w-1:0] lhps);
  int k;
  k = slot_of(onehot);
  if (onehot == '0)
    return '0;
  return lhps[k*jump_w +: jump_w];
endfunction

function automatic logic [stat_w-1:0] train_step(input logic [stat_w-1:0] stat, input logic ok);
  if (ok)
    return (stat == stat_max) ? stat : stat + stat_w'(1);
  return (stat == '0) ? stat : stat - stat_w'(1);
endfunction

task automatic model_reset();
  for (int t = 0; t < meta_pred_pkg::n_branch_types; t++)
  begin
    for (int e = 0; e < 2; e++)
      sp_tab[t][e] = stat_w'(sp_init);
    for (int e = 0; e < jump_states; e++)
    begin
      lhp_tab[t][e] = '0;
      ghp_tab[t][e] = '0;
    end
  end
endtask

task automatic model_update(input logic [5:0] onehot, input logic sp,
                            input logic [jump_w-1:0] ghp, input logic [lhp_w-1:0] lhps,
                            input logic outcome);
  int k;
  logic [jump_w-1:0] lc;
  logic [stat_w-1:0] sp_new, lhp_new, ghp_new;
  k = slot_of(onehot);
  lc = local_count(onehot, lhps);
  sp_new  = train_step(sp_tab[k][sp], sp == outcome);
  lhp_new = train_step(lhp_tab[k][lc], lc[jump_w-1] == outcome);
  ghp_new = train_step(ghp_tab[k][ghp], ghp[jump_w-1] == outcome);
  if (sp_new == stat_max || lhp_new == stat_max || ghp_new == stat_max)
  begin
    for (int e = 0; e < 2; e++)
      sp_tab[k][e] = sp_tab[k][e] & ~low_mask;
    for (int e = 0; e < jump_states; e++)
    begin
      lhp_tab[k][e] = lhp_tab[k][e] & ~low_mask;
      ghp_tab[k][e] = ghp_tab[k][e] & ~low_mask;
    end
    sp_new  = sp_new & ~low_mask; // Touched ones keep the high half
    lhp_new = lhp_new & ~low_mask;
    ghp_new = ghp_new & ~low_mask;
  end
  sp_tab[k][sp]   = sp_new;
  lhp_tab[k][lc]  = lhp_new;
  ghp_tab[k][ghp] = ghp_new;
endtask

// Most trusted wins, ties go static, local, global
function automatic logic model_predict(input logic [5:0] onehot, input logic sp,
                                       input logic [jump_w-1:0] ghp,
                                       input logic [lhp_w-1:0] lhps);
  int k;
  logic [jump_w-1:0] lc;
  logic [stat_w-1:0] s, l, g;
  k = slot_of(onehot);
  lc = local_count(onehot, lhps);
  s = sp_tab[k][sp];
  l = lhp_tab[k][lc];
  g = ghp_tab[k][ghp];
  if (s >= l && s >= g)
    return sp;
  else if (l >= g)
    return lc[jump_w-1];
  return ghp[jump_w-1];
endfunction

`endif

// ==== tb_meta_predictor.sv ====
`timescale 1ns/1ps

module tb_meta_predictor;

  localparam int jump_w          = 2;
  localparam int stat_w          = 5;
  localparam int clear_bits      = 3;
  localparam int sp_init         = 8;
  localparam int jump_states     = 1 << jump_w;
  localparam int lhp_w           = 6 * jump_w;
  localparam int clk_period      = 8;
  localparam int random_cycles   = 2000;
  localparam int directed_cycles = 24 + 18 + 12 + 31; // reset, tie, floor, aging
  localparam int timeout_ns = (16 + directed_cycles + random_cycles) * clk_period * 2;

  logic              clk = 1'b0;
  logic              rst_n;
  logic [5:0]        branch_type;
  logic              sp_taken;
  logic [jump_w-1:0] ghp_count;
  logic [lhp_w-1:0]  lhp_counts;
  logic              update_en;
  logic [5:0]        upd_branch_type;
  logic              upd_sp_taken;
  logic [jump_w-1:0] upd_ghp_count;
  logic [lhp_w-1:0]  upd_lhp_counts;
  logic              upd_outcome;
  logic              prediction_result;

  int checks = 0;
  int errors = 0;

  `include "meta_pred_model.svh"

  meta_predictor_top #(
    .jump_w(jump_w), .stat_w(stat_w), .clear_bits(clear_bits), .sp_init(sp_init)
  ) i_dut (
    .clk(clk), .rst_n(rst_n),
    .branch_type(branch_type), .sp_taken(sp_taken),
    .ghp_count(ghp_count), .lhp_counts(lhp_counts),
    .update_en(update_en), .upd_branch_type(upd_branch_type),
    .upd_sp_taken(upd_sp_taken), .upd_ghp_count(upd_ghp_count),
    .upd_lhp_counts(upd_lhp_counts), .upd_outcome(upd_outcome),
    .prediction_result(prediction_result)
  );

  always #(clk_period / 2) clk = ~clk;

  // ########################################
  // Drivers and checks
  // ########################################

  task automatic set_lookup(input logic [5:0] bt, input logic sp,
                            input logic [jump_w-1:0] ghp, input logic [lhp_w-1:0] lhps);
    branch_type = bt;
    sp_taken    = sp;
    ghp_count   = ghp;
    lhp_counts  = lhps;
  endtask

  task automatic set_update(input logic en, input logic [5:0] bt, input logic sp,
                            input logic [jump_w-1:0] ghp, input logic [lhp_w-1:0] lhps,
                            input logic outcome);
    update_en       = en;
    upd_branch_type = bt;
    upd_sp_taken    = sp;
    upd_ghp_count   = ghp;
    upd_lhp_counts  = lhps;
    upd_outcome     = outcome;
  endtask

  function automatic logic [lhp_w-1:0] place_local(input int k, input logic [jump_w-1:0] v);
    logic [lhp_w-1:0] f;
    f = '0;
    f[k*jump_w +: jump_w] = v;
    return f;
  endfunction

  task automatic compare_value(input string name, input int exp, input int act);
    checks++;
    assert (exp == act)
    else
    begin
      errors++;
      $display("error: %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Check mid-cycle, then follow the edge in the model
  task automatic step_and_check(input string name, input int fixed = -1);
    @(negedge clk);
    compare_value(name, int'(model_predict(branch_type, sp_taken, ghp_count, lhp_counts)),
                  int'(prediction_result));
    if (fixed >= 0)
      compare_value({name, "_fixed"}, fixed, int'(prediction_result));
    @(posedge clk);
    if (update_en)
      model_update(upd_branch_type, upd_sp_taken, upd_ghp_count, upd_lhp_counts, upd_outcome);
    #1;
  endtask

  task automatic check_tables(input string name, input int k);
    for (int e = 0; e < 2; e++)
      compare_value(name, sp_tab[k][e], i_dut.i_sp_bank.stats[k][e]);
    for (int e = 0; e < jump_states; e++)
    begin
      compare_value(name, lhp_tab[k][e], i_dut.i_lhp_bank.stats[k][e]);
      compare_value(name, ghp_tab[k][e], i_dut.i_ghp_bank.stats[k][e]);
    end
  endtask

  // ########################################
  // Stimulus
  // ########################################

  initial
  begin
    logic [5:0] lk_bt, up_bt, bne_bt, beq_bt;
    logic sp, up_sp, outcome;
    void'($urandom(15));
    bne_bt = 6'(1 << meta_pred_pkg::bne_idx);
    beq_bt = 6'(1 << meta_pred_pkg::beq_idx);
    rst_n = 1'b0;
    set_lookup('0, 1'b0, '0, '0);
    set_update(1'b0, '0, 1'b0, '0, '0, 1'b0);
    model_reset();
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int t = 0; t < 6; t++)
    begin
      repeat (4)
      begin
        sp = 1'($urandom);
        set_lookup(6'(1 << t), sp, jump_w'($urandom), lhp_w'($urandom));
        step_and_check("after_reset", int'(sp)); // Static starts ahead
      end
    end

    // Static wrong, both others right, in two state sets
    repeat (8)
    begin
      set_update(1'b1, bne_bt, 1'b1, 2'b00, place_local(4, 2'b01), 1'b0);
      set_lookup(bne_bt, 1'b1, 2'b00, place_local(4, 2'b01));
      step_and_check("tie_order_train");
    end
    repeat (8)
    begin
      set_update(1'b1, bne_bt, 1'b0, 2'b11, place_local(4, 2'b10), 1'b1);
      set_lookup(bne_bt, 1'b0, 2'b11, place_local(4, 2'b10));
      step_and_check("tie_order_train");
    end
    set_update(1'b0, '0, 1'b0, '0, '0, 1'b0);
    set_lookup(bne_bt, 1'b1, 2'b11, place_local(4, 2'b01));
    step_and_check("tie_order", 0);
    set_lookup(bne_bt, 1'b0, 2'b00, place_local(4, 2'b10));
    step_and_check("tie_order", 1);

    repeat (10)
    begin
      set_update(1'b1, bne_bt, 1'b1, 2'b11, place_local(4, 2'b10), 1'b0);
      set_lookup(bne_bt, 1'b1, 2'b11, place_local(4, 2'b10));
      step_and_check("floor_sat");
    end
    set_update(1'b0, '0, 1'b0, '0, '0, 1'b0);
    set_lookup(bne_bt, 1'b1, 2'b00, place_local(4, 2'b10));
    step_and_check("floor_sat", 0); // Static and local at 0, global still 8
    set_lookup(bne_bt, 1'b0, 2'b11, place_local(4, 2'b01));
    step_and_check("floor_sat", 0); // Global at 0, local still 8

    // 5 + 18 right static updates reach 31
    repeat (5)
    begin
      set_update(1'b1, beq_bt, 1'b1, 2'b00, place_local(5, 2'b11), 1'b1);
      step_and_check("aging_train");
    end
    repeat (18)
    begin
      set_update(1'b1, beq_bt, 1'b1, 2'b00, place_local(5, 2'b00), 1'b1);
      step_and_check("aging_train");
    end
    set_update(1'b0, '0, 1'b0, '0, '0, 1'b0);
    check_tables("aging_tables", meta_pred_pkg::beq_idx);
    check_tables("aging_other_type", meta_pred_pkg::bne_idx);
    for (int s = 0; s < jump_states; s++)
    begin
      set_lookup(beq_bt, 1'(s), jump_w'(s), place_local(5, jump_w'(s)));
      step_and_check("aging_lookup");
      set_lookup(bne_bt, 1'(s), jump_w'(s), place_local(4, jump_w'(s)));
      step_and_check("aging_other_lookup");
    end

    for (int i = 0; i < random_cycles; i++)
    begin
      lk_bt = 6'(1 << ($urandom % 6));
      up_bt = ($urandom % 4 == 0) ? lk_bt : 6'(1 << ($urandom % 6));
      up_sp = 1'($urandom);
      outcome = ($urandom % 4 != 0) ? up_sp : ~up_sp; // Leans static, ages now and then
      set_lookup(lk_bt, 1'($urandom), jump_w'($urandom), lhp_w'($urandom));
      set_update(1'($urandom), up_bt, up_sp, jump_w'($urandom), lhp_w'($urandom), outcome);
      step_and_check("random");
    end

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(timeout_ns);
    $display("timeout: the run did not finish within %0d ns", timeout_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== meta_predictor_top.sv ====
`timescale 1ns/1ps

module meta_predictor_top #(
  parameter int jump_w     = 2,
  parameter int stat_w     = 5,
  parameter int clear_bits = (stat_w + 1) / 2,
  parameter int sp_init    = 1 << clear_bits
)(
  input  logic                clk,
  input  logic                rst_n,

  // Lookup
  input  logic [5:0]          branch_type,
  input  logic                sp_taken,
  input  logic [jump_w-1:0]   ghp_count,
  input  logic [6*jump_w-1:0] lhp_counts,

  // Update
  input  logic                update_en,
  input  logic [5:0]          upd_branch_type,
  input  logic                upd_sp_taken,
  input  logic [jump_w-1:0]   upd_ghp_count,
  input  logic [6*jump_w-1:0] upd_lhp_counts,
  input  logic                upd_outcome,

  output logic                prediction_result
);

  localparam int jump_states = 1 << jump_w;

  meta_pred_pkg::type_idx_t lk_type_idx, up_type_idx;
  logic [jump_w-1:0] lk_lhp_count, up_lhp_count;

  logic [stat_w-1:0] sp_rd_stat, lhp_rd_stat, ghp_rd_stat;
  logic [stat_w-1:0] sp_upd_stat, lhp_upd_stat, ghp_upd_stat;

  logic              sp_wr_en, lhp_wr_en, ghp_wr_en;
  logic [stat_w-1:0] sp_wr_value, lhp_wr_value, ghp_wr_value;
  logic              age_en;
  logic              sp_entry;
  logic [jump_w-1:0] lhp_entry, ghp_entry;

  // ########################################
  // Slot selectors
  // ########################################

  branch_slot_select #(.jump_w(jump_w)) i_lookup_slot (
    .branch_type (branch_type),
    .lhp_counts  (lhp_counts),
    .type_idx    (lk_type_idx),
    .lhp_count   (lk_lhp_count)
  );

  branch_slot_select #(.jump_w(jump_w)) i_update_slot (
    .branch_type (upd_branch_type),
    .lhp_counts  (upd_lhp_counts),
    .type_idx    (up_type_idx),
    .lhp_count   (up_lhp_count)
  );

  // ########################################
  // Confidence banks
  // ########################################

  confidence_bank #(
    .entries(2), .stat_w(stat_w), .clear_bits(clear_bits), .init_value(stat_w'(sp_init))
  ) i_sp_bank (
    .clk(clk), .rst_n(rst_n),
    .rd_type(lk_type_idx), .rd_entry(sp_taken), .rd_stat(sp_rd_stat),
    .upd_type(up_type_idx), .upd_entry(sp_entry), .upd_stat(sp_upd_stat),
    .wr_en(sp_wr_en), .wr_value(sp_wr_value), .age_en(age_en)
  );

  confidence_bank #(
    .entries(jump_states), .stat_w(stat_w), .clear_bits(clear_bits), .init_value('0)
  ) i_lhp_bank (
    .clk(clk), .rst_n(rst_n),
    .rd_type(lk_type_idx), .rd_entry(lk_lhp_count), .rd_stat(lhp_rd_stat),
    .upd_type(up_type_idx), .upd_entry(lhp_entry), .upd_stat(lhp_upd_stat),
    .wr_en(lhp_wr_en), .wr_value(lhp_wr_value), .age_en(age_en)
  );

  confidence_bank #(
    .entries(jump_states), .stat_w(stat_w), .clear_bits(clear_bits), .init_value('0)
  ) i_ghp_bank (
    .clk(clk), .rst_n(rst_n),
    .rd_type(lk_type_idx), .rd_entry(ghp_count), .rd_stat(ghp_rd_stat),
    .upd_type(up_type_idx), .upd_entry(ghp_entry), .upd_stat(ghp_upd_stat),
    .wr_en(ghp_wr_en), .wr_value(ghp_wr_value), .age_en(age_en)
  );

  // ########################################
  // Training and selection
  // ########################################

  confidence_update_ctrl #(
    .jump_w(jump_w), .stat_w(stat_w), .clear_bits(clear_bits)
  ) i_update_ctrl (
    .update_en(update_en), .upd_outcome(upd_outcome),
    .upd_sp_taken(upd_sp_taken), .upd_ghp_count(upd_ghp_count),
    .upd_lhp_count(up_lhp_count),
    .sp_stat(sp_upd_stat), .lhp_stat(lhp_upd_stat), .ghp_stat(ghp_upd_stat),
    .sp_wr_en(sp_wr_en), .lhp_wr_en(lhp_wr_en), .ghp_wr_en(ghp_wr_en),
    .sp_wr_value(sp_wr_value), .lhp_wr_value(lhp_wr_value), .ghp_wr_value(ghp_wr_value),
    .age_en(age_en),
    .sp_entry(sp_entry), .lhp_entry(lhp_entry), .ghp_entry(ghp_entry)
  );

  component_arbiter #(.stat_w(stat_w)) i_arbiter (
    .sp_stat(sp_rd_stat), .lhp_stat(lhp_rd_stat), .ghp_stat(ghp_rd_stat),
    .sp_dir(sp_taken),
    .lhp_dir(lk_lhp_count[jump_w-1]), // Counter MSB is its direction
    .ghp_dir(ghp_count[jump_w-1]),
    .prediction_result(prediction_result)
  );

endmodule

// ==== component_arbiter.sv ====
`timescale 1ns/1ps

module component_arbiter #(
  parameter int stat_w = 5
)(
  input  logic [stat_w-1:0] sp_stat,
  input  logic [stat_w-1:0] lhp_stat,
  input  logic [stat_w-1:0] ghp_stat,
  input  logic              sp_dir,
  input  logic              lhp_dir,
  input  logic              ghp_dir,
  output logic              prediction_result
);

  logic sp_wins;
  logic lhp_wins;

  // Ties resolve static, then local, then global
  assign sp_wins  = (sp_stat >= lhp_stat) && (sp_stat >= ghp_stat);
  assign lhp_wins = (lhp_stat >= ghp_stat);

  always_comb
  begin
    if (sp_wins)
      prediction_result = sp_dir;
    else if (lhp_wins)
      prediction_result = lhp_dir; // Static already lost
    else
      prediction_result = ghp_dir;
  end

endmodule

// ==== confidence_update_ctrl.sv ====
`timescale 1ns/1ps

module confidence_update_ctrl #(
  parameter int jump_w     = 2,
  parameter int stat_w     = 5,
  parameter int clear_bits = 3
)(
  input  logic              update_en,
  input  logic              upd_outcome,   // Resolved direction
  input  logic              upd_sp_taken,
  input  logic [jump_w-1:0] upd_ghp_count,
  input  logic [jump_w-1:0] upd_lhp_count,

  input  logic [stat_w-1:0] sp_stat,
  input  logic [stat_w-1:0] lhp_stat,
  input  logic [stat_w-1:0] ghp_stat,

  output logic              sp_wr_en,
  output logic              lhp_wr_en,
  output logic              ghp_wr_en,
  output logic [stat_w-1:0] sp_wr_value,
  output logic [stat_w-1:0] lhp_wr_value,
  output logic [stat_w-1:0] ghp_wr_value,
  output logic              age_en,

  output logic              sp_entry,
  output logic [jump_w-1:0] lhp_entry,
  output logic [jump_w-1:0] ghp_entry
);

  localparam logic [stat_w-1:0] stat_max = '1;
  localparam logic [stat_w-1:0] low_mask = stat_w'((1 << clear_bits) - 1);

  logic              sp_ok, lhp_ok, ghp_ok;
  logic [stat_w-1:0] sp_new, lhp_new, ghp_new;

  // Saturating up when right, down when wrong
  function automatic logic [stat_w-1:0] step(input logic [stat_w-1:0] stat, input logic ok);
    logic [stat_w-1:0] res;
    if (ok)
      res = (stat == stat_max) ? stat : stat + 1'b1;
    else
      res = (stat == '0) ? stat : stat - 1'b1;
    return res;
  endfunction

  // ########################################
  // Judge components
  // ########################################

  assign sp_ok  = (upd_sp_taken == upd_outcome);
  assign lhp_ok = (upd_lhp_count[jump_w-1] == upd_outcome); // MSB is the direction
  assign ghp_ok = (upd_ghp_count[jump_w-1] == upd_outcome);

  assign sp_new  = step(sp_stat, sp_ok);
  assign lhp_new = step(lhp_stat, lhp_ok);
  assign ghp_new = step(ghp_stat, ghp_ok);

  // ########################################
  // Writes and aging
  // ########################################

  assign sp_wr_en  = update_en;
  assign lhp_wr_en = update_en;
  assign ghp_wr_en = update_en;

  assign age_en = update_en &&
                  (sp_new == stat_max || lhp_new == stat_max || ghp_new == stat_max);

  // Touched counters keep only their high half on aging
  assign sp_wr_value  = age_en ? (sp_new & ~low_mask) : sp_new;
  assign lhp_wr_value = age_en ? (lhp_new & ~low_mask) : lhp_new;
  assign ghp_wr_value = age_en ? (ghp_new & ~low_mask) : ghp_new;

  assign sp_entry  = upd_sp_taken;
  assign lhp_entry = upd_lhp_count;
  assign ghp_entry = upd_ghp_count;

endmodule

// ==== confidence_bank.sv ====
`timescale 1ns/1ps

module confidence_bank #(
  parameter int               entries    = 4,
  parameter int               stat_w     = 5,
  parameter int               clear_bits = 3,
  parameter logic [stat_w-1:0] init_value = '0
)(
  input  logic                       clk,
  input  logic                       rst_n,

  input  meta_pred_pkg::type_idx_t   rd_type,
  input  logic [$clog2(entries)-1:0] rd_entry,
  output logic [stat_w-1:0]          rd_stat,

  input  meta_pred_pkg::type_idx_t   upd_type,
  input  logic [$clog2(entries)-1:0] upd_entry,
  output logic [stat_w-1:0]          upd_stat,

  input  logic                       wr_en,
  input  logic [stat_w-1:0]          wr_value,
  input  logic                       age_en
);

  logic [stat_w-1:0] stats [meta_pred_pkg::n_branch_types][entries];

  // ########################################
  // Reads
  // ########################################

  assign rd_stat  = stats[rd_type][rd_entry];   // Lookup port
  assign upd_stat = stats[upd_type][upd_entry]; // Feeds the controller

  // ########################################
  // Write and aging
  // ########################################

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int t = 0; t < meta_pred_pkg::n_branch_types; t++)
      begin
        for (int e = 0; e < entries; e++)
        begin
          stats[t][e] <= init_value;
        end
      end
    end
    else
    begin
      // Age every counter of the type
      if (age_en)
      begin
        for (int e = 0; e < entries; e++)
        begin
          stats[upd_type][e][clear_bits-1:0] <= '0;
        end
      end
      // Touched counter last, value arrives already aged
      if (wr_en)
        stats[upd_type][upd_entry] <= wr_value;
    end
  end

  // Controller must stay idle while the tables reload
  assert property (@(posedge clk) !rst_n |-> !(wr_en || age_en))
    else $error("confidence_bank: write or aging during reset");

endmodule

// ==== branch_slot_select.sv ====
`timescale 1ns/1ps

module branch_slot_select #(
  parameter int jump_w = 2
)(
  input  logic [5:0]          branch_type, // One-hot, beq in bit 5
  input  logic [6*jump_w-1:0] lhp_counts,
  output meta_pred_pkg::type_idx_t type_idx,
  output logic [jump_w-1:0]   lhp_count
);

  // One-hot to index
  always_comb
  begin
    case (branch_type)
      6'b100000: type_idx = meta_pred_pkg::beq_idx;
      6'b010000: type_idx = meta_pred_pkg::bne_idx;
      6'b001000: type_idx = meta_pred_pkg::blt_idx;
      6'b000100: type_idx = meta_pred_pkg::bge_idx;
      6'b000010: type_idx = meta_pred_pkg::bltu_idx;
      6'b000001: type_idx = meta_pred_pkg::bgeu_idx;
      default:   type_idx = '0;
    endcase
  end

  // Local counter of the selected type, zero when no branch
  always_comb
  begin
    if (branch_type == '0)
      lhp_count = '0;
    else
      lhp_count = lhp_counts[type_idx*jump_w +: jump_w];
  end

  // Decode stage hands over at most one type per cycle
  always_comb
  begin
    if (!$isunknown(branch_type))
      assert ($onehot0(branch_type))
        else $error("branch_slot_select: more than one branch type set %b", branch_type);
  end

endmodule

// ==== meta_pred_pkg.sv ====
package meta_pred_pkg;

  // ########################################
  // Branch types
  // ########################################

  localparam int n_branch_types = 6; // beq bne blt bge bltu bgeu
  localparam int type_idx_w     = 3;

  // Index k matches one-hot bit k
  typedef logic [type_idx_w-1:0] type_idx_t;

  localparam type_idx_t beq_idx  = 3'd5;
  localparam type_idx_t bne_idx  = 3'd4;
  localparam type_idx_t blt_idx  = 3'd3;
  localparam type_idx_t bge_idx  = 3'd2;
  localparam type_idx_t bltu_idx = 3'd1;
  localparam type_idx_t bgeu_idx = 3'd0;

endpackage
